// ==== common/router_pkg.sv ====
package router_pkg;

	localparam int FLIT_W = 32;
	localparam int NUM_PORTS = 5;
	localparam int PAYLOAD_W = FLIT_W - 12; // kind, reserved and coordinates take the top 12 bits

	// flit kind lives in the two top bits
	typedef enum logic [1:0] {
		KIND_BODY = 2'b00,
		KIND_HEAD = 2'b01,
		KIND_MID  = 2'b10, // handled as body
		KIND_TAIL = 2'b11
	} flit_kind_e;

	typedef logic [1:0] coord_t; // mesh position, 4x4 at most

	typedef struct packed {
		flit_kind_e             kind;
		logic [5:0]             reserved;
		coord_t                 dest_x; // head only
		coord_t                 dest_y; // head only
		logic [PAYLOAD_W-1:0]   payload;
	} flit_t;

	typedef enum logic [2:0] {
		PORT_NORTH = 3'd0,
		PORT_SOUTH = 3'd1,
		PORT_EAST  = 3'd2,
		PORT_WEST  = 3'd3,
		PORT_LOCAL = 3'd4
	} port_e;

	// shown on an output that carries nothing
	localparam flit_t IDLE_FLIT = flit_t'({{(FLIT_W-1){1'b0}}, 1'b1});

	// one link between neighbouring routers
	typedef struct packed {
		logic  push;
		flit_t flit;
	} link_t;

endpackage

// ==== input_port/input_port.sv ====
`timescale 1ns/1ps

module input_port #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             enable,
	input  router_pkg::coord_t               router_x,
	input  router_pkg::coord_t               router_y,
	input  router_pkg::link_t                in_link,
	input  logic                             pop,
	output logic [$clog2(FIFO_DEPTH+1)-1:0]  count,
	output router_pkg::flit_t                front,
	output logic                             front_valid,
	output logic                             request,
	output router_pkg::port_e                route
);
	import router_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	flit_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic             in_pkt; // head popped, tail not yet
	logic             full;
	logic             do_push;
	logic             do_pop;
	logic             drop_stray;

	// depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full        = (count == CNT_W'(FIFO_DEPTH));
	assign front       = mem[rd_ptr];
	assign front_valid = (count != '0);
	assign request     = front_valid && !in_pkt && (front.kind == KIND_HEAD);

	// body or tail with no packet open has nowhere to go
	assign drop_stray = enable && front_valid && !in_pkt && (front.kind != KIND_HEAD);

	assign do_push = enable && in_link.push && !full; // lost when full
	assign do_pop  = front_valid && (pop || drop_stray);

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= in_link.flit;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
			in_pkt <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
			if (do_pop && front.kind == KIND_HEAD) begin
				in_pkt <= 1'b1;
			end else if (do_pop && front.kind == KIND_TAIL) begin
				in_pkt <= 1'b0;
			end
		end
	end

	// XY order, x settled first
	always_comb begin
		if (front.dest_x > router_x) begin
			route = PORT_EAST;
		end else if (front.dest_x < router_x) begin
			route = PORT_WEST;
		end else if (front.dest_y > router_y) begin
			route = PORT_NORTH;
		end else if (front.dest_y < router_y) begin
			route = PORT_SOUTH;
		end else begin
			route = PORT_LOCAL; // arrived
		end
	end

endmodule

// ==== logic/router.sv ====
`timescale 1ns/1ps

module router #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                                           clk,
	input  logic                                                           reset,
	input  logic                                                           enable,
	input  router_pkg::coord_t                                             router_x,
	input  router_pkg::coord_t                                             router_y,
	input  router_pkg::link_t [router_pkg::NUM_PORTS-1:0]                  in_link,
	input  logic [router_pkg::NUM_PORTS-1:0][$clog2(FIFO_DEPTH+1)-1:0]     in_count,
	output router_pkg::link_t [router_pkg::NUM_PORTS-1:0]                  out_link,
	output logic [router_pkg::NUM_PORTS-1:0][$clog2(FIFO_DEPTH+1)-1:0]     out_count
);
	import router_pkg::*;

	// per input
	flit_t [NUM_PORTS-1:0]                 fronts;
	logic  [NUM_PORTS-1:0]                 front_valids;
	logic  [NUM_PORTS-1:0]                 requests;
	port_e [NUM_PORTS-1:0]                 route;
	logic  [NUM_PORTS-1:0]                 in_pop;

	// indexed [output][input]
	logic  [NUM_PORTS-1:0][NUM_PORTS-1:0]  masked_req;
	logic  [NUM_PORTS-1:0][NUM_PORTS-1:0]  out_pop;

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
		input_port #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) i_input (
			.clk         (clk),
			.reset       (reset),
			.enable      (enable),
			.router_x    (router_x),
			.router_y    (router_y),
			.in_link     (in_link[i]),
			.pop         (in_pop[i]),
			.count       (out_count[i]),
			.front       (fronts[i]),
			.front_valid (front_valids[i]),
			.request     (requests[i]),
			.route       (route[i])
		);
	end

	// each output sees only heads routed to it
	// at most one output pops a given input, so OR is enough
	always_comb begin
		in_pop = '0;
		for (int o = 0; o < NUM_PORTS; o++) begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				masked_req[o][i] = requests[i] && (int'(route[i]) == o);
				in_pop[i] = in_pop[i] | out_pop[o][i];
			end
		end
	end

	for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
		output_port #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) i_output (
			.clk          (clk),
			.reset        (reset),
			.enable       (enable),
			.requests     (masked_req[o]),
			.fronts       (fronts),
			.front_valids (front_valids),
			.down_count   (in_count[o]), // neighbour buffer fed by this output
			.pop          (out_pop[o]),
			.out_link     (out_link[o])
		);
	end

endmodule

// ==== output_port/output_port.sv ====
`timescale 1ns/1ps

module output_port #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                                                clk,
	input  logic                                                reset,
	input  logic                                                enable,
	input  logic [router_pkg::NUM_PORTS-1:0]                    requests,
	input  router_pkg::flit_t [router_pkg::NUM_PORTS-1:0]       fronts,
	input  logic [router_pkg::NUM_PORTS-1:0]                    front_valids,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0]                     down_count,
	output logic [router_pkg::NUM_PORTS-1:0]                    pop,
	output router_pkg::link_t                                   out_link
);
	import router_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic  busy;       // a packet owns this output
	port_e owner;      // input holding the grant
	port_e arb_grant;
	logic  arb_valid;
	logic  credit_ok;
	port_e sel;
	flit_t sel_flit;
	logic  fwd;        // pop and register this cycle
	logic  new_grant;

	// downstream buffer must have room
	assign credit_ok = (down_count < CNT_W'(FIFO_DEPTH));

	rr_arbiter i_arbiter (
		.clk         (clk),
		.reset       (reset),
		.advance     (new_grant),
		.requests    (requests),
		.grant       (arb_grant),
		.grant_valid (arb_valid)
	);

	// crossbar select for this output
	always_comb begin
		sel      = busy ? owner : arb_grant;
		sel_flit = fronts[sel];
	end

	always_comb begin
		if (busy) begin
			fwd = enable && credit_ok && front_valids[owner];
		end else begin
			fwd = enable && credit_ok && arb_valid; // head only
		end
	end

	assign new_grant = fwd && !busy;

	always_comb begin
		pop = '0;
		if (fwd) begin
			pop[sel] = 1'b1;
		end
	end

	// grant held until the tail goes out
	always_ff @(posedge clk) begin
		if (reset) begin
			busy  <= 1'b0;
			owner <= PORT_NORTH;
		end else begin
			if (fwd) begin
				busy <= (sel_flit.kind != KIND_TAIL);
			end
			if (new_grant) begin
				owner <= arb_grant;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_link.push <= 1'b0;
			out_link.flit <= IDLE_FLIT;
		end else begin
			out_link.push <= fwd; // one cycle per flit
			out_link.flit <= fwd ? sel_flit : IDLE_FLIT;
		end
	end

endmodule

// ==== output_port/rr_arbiter.sv ====
`timescale 1ns/1ps

module rr_arbiter (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             advance,
	input  logic [router_pkg::NUM_PORTS-1:0] requests,
	output router_pkg::port_e                grant,
	output logic                             grant_valid
);
	import router_pkg::*;

	port_e ptr; // highest priority input

	// first requester at or after ptr, wrapping
	always_comb begin
		int idx;
		grant       = PORT_NORTH;
		grant_valid = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++) begin
			idx = (int'(ptr) + i) % NUM_PORTS;
			if (!grant_valid && requests[idx]) begin
				grant       = port_e'(idx);
				grant_valid = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= PORT_NORTH;
		end else if (advance && grant_valid) begin
			// winner drops to lowest priority
			if (grant == PORT_LOCAL) begin
				ptr <= PORT_NORTH;
			end else begin
				ptr <= port_e'(int'(grant) + 1);
			end
		end
	end

endmodule

// ==== router.f ====
common/router_pkg.sv
input_port/input_port.sv
output_port/rr_arbiter.sv
output_port/output_port.sv
logic/router.sv
verif/router_asserts.sv
verif/router_checker.sv
verif/router_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module router_tb \
	--Mdir obj_dir \
	-o router_sim \
	-f router.f

./obj_dir/router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
	exit 0
fi
exit 1

// ==== verif/router_asserts.sv ====
`timescale 1ns/1ps

module router_asserts #(
	parameter int FIFO_DEPTH = 4
) (
	input logic                                                       clk,
	input logic                                                       reset,
	input logic                                                       enable,
	input logic [router_pkg::NUM_PORTS-1:0][$clog2(FIFO_DEPTH+1)-1:0] in_count,
	input router_pkg::link_t [router_pkg::NUM_PORTS-1:0]              out_link,
	input logic [router_pkg::NUM_PORTS-1:0][router_pkg::NUM_PORTS-1:0] out_pop
);
	import router_pkg::*;

	for (genvar o = 0; o < NUM_PORTS; o++) begin : g_credit
		a_credit: assert property (@(posedge clk) disable iff (reset)
			(in_count[o] >= FIFO_DEPTH) |=> !out_link[o].push)
			else $error("output %0d pushed with downstream full", o);
		a_freeze: assert property (@(posedge clk) disable iff (reset)
			!enable |=> !out_link[o].push)
			else $error("output %0d pushed while frozen", o);
	end

	for (genvar i = 0; i < NUM_PORTS; i++) begin : g_pop
		a_one_pop: assert property (@(posedge clk) disable iff (reset)
			$countones({out_pop[0][i], out_pop[1][i], out_pop[2][i], out_pop[3][i],
				out_pop[4][i]}) <= 1)
			else $error("input %0d popped by two outputs", i);
	end

endmodule

bind router router_asserts #(.FIFO_DEPTH(FIFO_DEPTH)) i_asserts (
	.clk      (clk),
	.reset    (reset),
	.enable   (enable),
	.in_count (in_count),
	.out_link (out_link),
	.out_pop  (out_pop)
);

// ==== verif/router_checker.sv ====
`timescale 1ns/1ps

module router_checker #(
	parameter int FIFO_DEPTH = 4,
	parameter int NUM_TESTS  = 14
) (
	input  logic                                                       clk,
	input  logic                                                       reset,
	input  logic                                                       enable,
	input  router_pkg::coord_t                                         router_x,
	input  router_pkg::coord_t                                         router_y,
	input  router_pkg::link_t [router_pkg::NUM_PORTS-1:0]              in_link,
	input  logic [router_pkg::NUM_PORTS-1:0]                           exp_mask,
	input  logic                                                       ord_push,
	input  router_pkg::port_e                                          ord_src,
	input  router_pkg::coord_t                                         ord_dx,
	input  router_pkg::coord_t                                         ord_dy,
	input  logic [router_pkg::NUM_PORTS-1:0][$clog2(FIFO_DEPTH+1)-1:0] in_count,
	input  router_pkg::link_t [router_pkg::NUM_PORTS-1:0]              out_link,
	input  logic [NUM_TESTS-1:0][63:0]                                 names,
	output int                                                         pending,
	output int                                                         errors
);
	import router_pkg::*;

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	flit_t                            src_q [NUM_PORTS][$]; // expected flits per source
	int                               ord_q [NUM_PORTS][$]; // expected packet order per output
	int                               owner [NUM_PORTS];
	logic                             busy  [NUM_PORTS];
	logic                             en_q;
	logic [NUM_PORTS-1:0][CNT_W-1:0]  cnt_q;

	// dimension order, x first
	function automatic int xy_port(input coord_t dx, input coord_t dy);
		if (dx > router_x) return int'(PORT_EAST);
		if (dx < router_x) return int'(PORT_WEST);
		if (dy > router_y) return int'(PORT_NORTH);
		if (dy < router_y) return int'(PORT_SOUTH);
		return int'(PORT_LOCAL);
	endfunction

	function automatic logic [63:0] test_name(input flit_t f);
		int id;
		id = int'(f.payload[PAYLOAD_W-1 -: 6]); // test id sits in the top payload bits
		return (id < NUM_TESTS) ? names[id] : "unknown_";
	endfunction

	always @(posedge clk) begin
		flit_t f;
		flit_t e;
		int    s;
		if (reset) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				src_q[p].delete();
				ord_q[p].delete();
				busy[p]  = 1'b0;
				owner[p] = 0;
			end
			pending = 0;
			errors  = 0;
		end else begin
			if (ord_push) begin
				ord_q[xy_port(ord_dx, ord_dy)].push_back(int'(ord_src));
			end
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (exp_mask[p] && in_link[p].push) begin
					src_q[p].push_back(in_link[p].flit);
					pending++;
				end
			end
			for (int o = 0; o < NUM_PORTS; o++) begin
				if (out_link[o].push) begin
					f = out_link[o].flit;
					if (!en_q) begin
						$display("output %0d pushed a flit while the router was frozen", o);
						errors++;
					end
					if (cnt_q[o] >= CNT_W'(FIFO_DEPTH)) begin
						$display("output %0d pushed a flit while downstream was full", o);
						errors++;
					end
					if (!busy[o] && ord_q[o].size() != 0) begin
						owner[o] = ord_q[o].pop_front(); // next packet in line owns it
						busy[o]  = 1'b1;
					end
					s = owner[o];
					if (!busy[o] || src_q[s].size() == 0) begin
						$display("unexpected flit %h on output %0d", f, o);
						errors++;
					end else begin
						e = src_q[s].pop_front();
						pending--;
						if (e != f) begin
							$display("mismatch %s output %0d expected %h actual %h",
								test_name(e), o, e, f);
							errors++;
						end
						if (e.kind == KIND_TAIL) begin
							busy[o] = 1'b0;
						end
					end
				end
			end
		end
		en_q  <= enable; // values seen by the edge that made the current output
		cnt_q <= in_count;
	end

endmodule

// ==== verif/router_tb.sv ====
`timescale 1ns/1ps

module router_tb;
	import router_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
	localparam int NUM_TESTS  = 14;

	typedef struct {
		logic [63:0] name;
		int src;
		int dx;
		int dy;
		int len;
		int delay;
		int hold;      // cycles the hold port sees a full downstream
		int hport;
		int freeze;    // cycles with enable low
		int stray;
		int overflow;
		int join_next; // next entry starts together with this one
	} test_t;

	logic                            clk;
	logic                            reset;
	logic                            enable;
	coord_t                          router_x;
	coord_t                          router_y;
	link_t [NUM_PORTS-1:0]           in_link;
	logic [NUM_PORTS-1:0][CNT_W-1:0] in_count;
	link_t [NUM_PORTS-1:0]           out_link;
	logic [NUM_PORTS-1:0][CNT_W-1:0] out_count;
	logic [NUM_PORTS-1:0]            exp_mask;
	logic                            ord_push;
	port_e                           ord_src;
	coord_t                          ord_dx;
	coord_t                          ord_dy;
	logic [NUM_TESTS-1:0][63:0]      names;
	int                              chk_pending;
	int                              chk_errors;

	test_t       tests [NUM_TESTS];
	flit_t       drv_flit [NUM_PORTS][$];
	int          drv_at   [NUM_PORTS][$];
	logic        drv_exp  [NUM_PORTS][$];
	int          ann_q [$];
	int          hold_until [NUM_PORTS];
	logic [31:0] rng_state = 32'd96;
	int          cycle;
	int          base;
	int          end_cycle;
	int          frz_from;
	int          frz_to;
	int          full_at;
	int          full_src;
	int          tb_errors;
	int          budget;
	logic [NUM_PORTS-1:0][CNT_W-1:0] frz_snap;

	router #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (
		.clk       (clk),
		.reset     (reset),
		.enable    (enable),
		.router_x  (router_x),
		.router_y  (router_y),
		.in_link   (in_link),
		.in_count  (in_count),
		.out_link  (out_link),
		.out_count (out_count)
	);

	router_checker #(.FIFO_DEPTH(FIFO_DEPTH), .NUM_TESTS(NUM_TESTS)) i_checker (
		.clk      (clk),
		.reset    (reset),
		.enable   (enable),
		.router_x (router_x),
		.router_y (router_y),
		.in_link  (in_link),
		.exp_mask (exp_mask),
		.ord_push (ord_push),
		.ord_src  (ord_src),
		.ord_dx   (ord_dx),
		.ord_dy   (ord_dy),
		.in_count (in_count),
		.out_link (out_link),
		.names    (names),
		.pending  (chk_pending),
		.errors   (chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic flit_t make_flit(input int t, input int k, input flit_kind_e kind);
		flit_t       f;
		logic [31:0] r;
		r         = next_random();
		f         = '0;
		f.kind    = kind;
		f.dest_x  = coord_t'(tests[t].dx);
		f.dest_y  = coord_t'(tests[t].dy);
		f.payload = {6'(t), 4'(k), r[9:0]}; // test id, flit index, random fill
		return f;
	endfunction

	task automatic add_flit(input int s, input flit_t f, input int at, input logic expected);
		drv_flit[s].push_back(f);
		drv_at[s].push_back(at);
		drv_exp[s].push_back(expected);
	endtask

	task automatic queue_packet(input int t);
		int         s;
		int         at;
		flit_kind_e kind;
		s  = tests[t].src;
		at = base + tests[t].delay;
		if (tests[t].stray != 0) begin
			add_flit(s, make_flit(t, 14, KIND_BODY), at, 1'b0); // no head in front
			add_flit(s, make_flit(t, 15, KIND_TAIL), at + 1, 1'b0);
			at = at + 2;
		end
		for (int k = 0; k < tests[t].len; k++) begin
			if (k == 0) kind = KIND_HEAD;
			else if (k == tests[t].len - 1) kind = KIND_TAIL;
			else kind = (k % 2 == 1) ? KIND_MID : KIND_BODY;
			add_flit(s, make_flit(t, k, kind), at + k, 1'b1);
		end
		if (tests[t].overflow != 0) begin
			add_flit(s, make_flit(t, 15, KIND_HEAD), at + tests[t].len, 1'b0); // fifo full
		end
	endtask

	// one cycle of stimulus, applied on the falling edge
	task automatic step();
		int t;
		@(negedge clk);
		cycle++;
		enable   = !(cycle >= frz_from && cycle < frz_to);
		ord_push = 1'b0;
		exp_mask = '0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			in_count[p] = (cycle < hold_until[p]) ? CNT_W'(FIFO_DEPTH) : '0;
			in_link[p]  = '0;
			if (enable && drv_flit[p].size() != 0 && drv_at[p][0] <= cycle) begin
				in_link[p].push = 1'b1;
				in_link[p].flit = drv_flit[p].pop_front();
				exp_mask[p]     = drv_exp[p].pop_front();
				void'(drv_at[p].pop_front());
				if (end_cycle < cycle + 2) end_cycle = cycle + 2;
			end
		end
		if (ann_q.size() != 0) begin
			t        = ann_q.pop_front();
			ord_push = 1'b1;
			ord_src  = port_e'(tests[t].src);
			ord_dx   = coord_t'(tests[t].dx);
			ord_dy   = coord_t'(tests[t].dy);
		end
		if (cycle == full_at && out_count[full_src] != CNT_W'(FIFO_DEPTH)) begin
			$display("mismatch %s out_count expected %0d actual %0d",
				tests[NUM_TESTS-3].name, FIFO_DEPTH, out_count[full_src]);
			tb_errors++;
		end
		if (cycle == frz_from) frz_snap = out_count;
		if (cycle > frz_from && cycle <= frz_to && out_count != frz_snap) begin
			$display("mismatch %s out_count expected %h actual %h",
				tests[NUM_TESTS-2].name, frz_snap, out_count);
			tb_errors++;
		end
	endtask

	function automatic logic traffic_left();
		for (int p = 0; p < NUM_PORTS; p++) begin
			if (drv_flit[p].size() != 0) return 1'b1;
		end
		return (chk_pending != 0) || (cycle < end_cycle);
	endfunction

	initial begin
		wait (budget > 0);
		#(budget * 8);
		$display("timeout: traffic did not drain in %0d cycles", budget);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int first;
		int last;
		int err_before;
		int failed_tests;
		int idx;
		reset    = 1'b1;
		enable   = 1'b1;
		router_x = 2'd1;
		router_y = 2'd1;
		in_link  = '0;
		in_count = '0;
		exp_mask = '0;
		ord_push = 1'b0;
		ord_src  = PORT_NORTH;
		ord_dx   = '0;
		ord_dy   = '0;
		cycle    = 0;
		tb_errors    = 0;
		failed_tests = 0;
		frz_from = 0;
		frz_to   = 0;
		full_at  = -1;
		full_src = 0;
		// name        src dx dy len dly hold hport frz stray ovf join
		tests[0]  = '{"xy_north", 1, 1, 2, 3, 0, 0,  0, 0, 0, 0, 0};
		tests[1]  = '{"xy_south", 0, 1, 0, 4, 0, 0,  0, 0, 0, 0, 0};
		tests[2]  = '{"xy_east_", 3, 3, 0, 2, 1, 0,  0, 0, 0, 0, 0};
		tests[3]  = '{"xy_west_", 2, 0, 3, 5, 0, 0,  0, 0, 0, 0, 0};
		tests[4]  = '{"xy_local", 4, 1, 1, 2, 0, 0,  0, 0, 0, 0, 0};
		tests[5]  = '{"rr_n_1st", 0, 1, 1, 3, 0, 0,  0, 0, 0, 0, 1};
		tests[6]  = '{"rr_s_2nd", 1, 1, 1, 3, 0, 0,  0, 0, 0, 0, 1};
		tests[7]  = '{"rr_e_3rd", 2, 1, 1, 3, 0, 0,  0, 0, 0, 0, 0};
		tests[8]  = '{"rr_w_1st", 3, 1, 1, 2, 0, 0,  0, 0, 0, 0, 1}; // priority now at west
		tests[9]  = '{"rr_n_2nd", 0, 1, 1, 4, 0, 0,  0, 0, 0, 0, 0};
		tests[10] = '{"backpres", 4, 3, 1, 4, 0, 10, 2, 0, 0, 0, 0};
		tests[11] = '{"overflow", 0, 0, 1, 4, 0, 14, 3, 0, 0, 1, 0};
		tests[12] = '{"freeze__", 2, 1, 0, 6, 0, 0,  0, 8, 0, 0, 0};
		tests[13] = '{"stray___", 3, 1, 3, 3, 0, 0,  0, 0, 1, 0, 0};
		idx = 20;
		for (int t = 0; t < NUM_TESTS; t++) begin
			names[t] = tests[t].name;
			idx = idx + tests[t].len + tests[t].delay + tests[t].hold + tests[t].freeze + 8;
		end
		for (int p = 0; p < NUM_PORTS; p++) hold_until[p] = 0;
		budget = idx * 20;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		idx   = 0;
		while (idx < NUM_TESTS) begin
			first = idx;
			last  = idx;
			while (tests[last].join_next != 0) last++;
			err_before = tb_errors + chk_errors;
			for (int t = first; t <= last; t++) ann_q.push_back(t);
			while (ann_q.size() != 0) step();
			base      = cycle + 1;
			end_cycle = base + 2;
			for (int t = first; t <= last; t++) begin
				queue_packet(t);
				if (tests[t].hold != 0) begin
					hold_until[tests[t].hport] = base + tests[t].hold;
					if (end_cycle < base + tests[t].hold + 2) end_cycle = base + tests[t].hold + 2;
				end
				if (tests[t].overflow != 0) begin
					full_at  = base + tests[t].hold - 1; // last cycle still blocked
					full_src = tests[t].src;
				end
				if (tests[t].freeze != 0) begin
					frz_from  = base + 2;
					frz_to    = base + 2 + tests[t].freeze;
					end_cycle = frz_to + 2;
				end
			end
			while (traffic_left()) step();
			for (int t = first; t <= last; t++) begin
				if (tb_errors + chk_errors == err_before) begin
					$display("test %s: ok", tests[t].name);
				end else begin
					$display("test %s: failed", tests[t].name);
					failed_tests++;
				end
			end
			idx = last + 1;
		end
		repeat (4) step();
		$display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests,
			tb_errors + chk_errors);
		if (failed_tests == 0 && tb_errors + chk_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
